// File: sdp_wdma_consts.svh
// ==========================================================================
// widths and counts for the SDP write-DMA input stage
// the beat router decode assumes exactly four FIFOs and a beat of two
// FIFO words; changing these alone does not re-route the data
// ==========================================================================
`ifndef SDP_WDMA_CONSTS_SVH
`define SDP_WDMA_CONSTS_SVH

// data path widths
`define SDP_WDMA_BEAT_W 256
`define SDP_WDMA_FIFO_W 128
`define SDP_WDMA_NUM_FIFO 4
`define SDP_WDMA_FP16_LANES 16

// span size and beat counter width
`define SDP_WDMA_SPAN_W 14

// status counter
`define SDP_WDMA_NAN_CNT_W 32
`define SDP_WDMA_FP16_EXP_ALL_ONES 5'h1f

`endif

// File: sdp_wdma_pkg.sv
// ==========================================================================
// shared types of the SDP write-DMA input stage
// out_prec_e keeps the register field encoding, value 3 is reserved
// ==========================================================================
`default_nettype none

`include "sdp_wdma_consts.svh"

package sdp_wdma_pkg;

  // output precision, same code as the register field
  typedef enum logic [1:0] {
    out_prec_int8  = 2'd0,
    out_prec_int16 = 2'd1,
    out_prec_fp16  = 2'd2
  } out_prec_e;

  // one IEEE half precision word
  typedef struct packed {
    logic       sign;
    logic [4:0] expo;
    logic [9:0] mant;
  } fp16_t;

  // one result beat, seen as bytes for routing or as fp16 lanes
  typedef union packed {
    logic [`SDP_WDMA_BEAT_W/8-1:0][7:0] bytes;
    fp16_t [`SDP_WDMA_FP16_LANES-1:0]   lanes;
  } wdma_beat_u;

endpackage

`default_nettype wire

// File: sdp_wdma_dfifo_if.sv
// ==========================================================================
// write side of the four data FIFOs, one valid/ready/word per channel
// channel k always belongs to FIFO k
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

interface sdp_wdma_dfifo_if;

  logic [`SDP_WDMA_NUM_FIFO-1:0]                      pvld;
  logic [`SDP_WDMA_NUM_FIFO-1:0]                      prdy;
  logic [`SDP_WDMA_NUM_FIFO-1:0][`SDP_WDMA_FIFO_W-1:0] pd;

  // router pushes words, FIFOs answer with ready
  modport router (
    output pvld,
    output pd,
    input  prdy
  );

  modport fifo (
    input  pvld,
    input  pd,
    output prdy
  );

endinterface

`default_nettype wire

// File: sdp_wdma_span_ctrl.sv
// ==========================================================================
// span command holder and beat counter
// a span is cmd_size+1 beats; the command is popped by its last beat,
// so a new one can be taken in that same cycle
// the data source must not send beats before their command
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module sdp_wdma_span_ctrl (
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  logic                        cmd_pvld,
  output logic                        cmd_prdy,
  input  logic [`SDP_WDMA_SPAN_W-1:0] cmd_size,
  input  logic                        dp_valid,
  input  logic                        beat_accept,
  output logic [`SDP_WDMA_SPAN_W-1:0] beat_count
);

  logic                        span_vld;
  logic [`SDP_WDMA_SPAN_W-1:0] span_size;
  logic                        last_beat;

  assign last_beat = (beat_count == span_size);

  // free, or freed by the last beat of the span
  assign cmd_prdy = !span_vld || (beat_accept && last_beat);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      span_vld <= 1'b0;
    end else if (cmd_prdy) begin
      span_vld <= cmd_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (cmd_pvld && cmd_prdy) begin
      span_size <= cmd_size;
    end
  end

  // beat position inside the span, back to 0 after the last one
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_count <= '0;
    end else if (beat_accept) begin
      if (last_beat) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count + 1'b1;
      end
    end
  end

  // ==========================================================================
  // protocol checks
  // ==========================================================================
  // the data path runs ahead of the command path otherwise
  a_data_after_cmd : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dp_valid |-> span_vld
  );

  a_cmd_size_known : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (cmd_pvld && cmd_prdy) |-> !$isunknown(cmd_size)
  );

endmodule

`default_nettype wire

// File: sdp_wdma_beat_router.sv
// ==========================================================================
// steers each result beat into the data FIFOs by its beat position
// int8: low half to FIFO (beat mod 4)
// int16/fp16: even beats to FIFOs 0/1, odd beats to 2/3, low then high
// a beat is pushed only when every FIFO it needs is ready
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module sdp_wdma_beat_router (
  input  logic                         dp_valid,
  input  sdp_wdma_pkg::wdma_beat_u     dp_pd,
  output logic                         dp_ready,
  input  sdp_wdma_pkg::out_prec_e      out_precision,
  input  logic [`SDP_WDMA_SPAN_W-1:0]  beat_count,
  output logic                         beat_accept,
  sdp_wdma_dfifo_if.router             wr
);

  localparam int NF = `SDP_WDMA_NUM_FIFO;
  // bytes in one FIFO word
  localparam int HB = `SDP_WDMA_FIFO_W / 8;

  logic          do_8;
  logic [NF-1:0] wr_en;
  logic [NF-1:0] fifo_rdy;

  assign do_8 = (out_precision == sdp_wdma_pkg::out_prec_int8);

  // per-FIFO enable from the low beat count bits
  always_comb begin
    for (int k = 0; k < NF; k++) begin
      if (do_8) begin
        wr_en[k] = (beat_count[1:0] == 2'(k));
      end else begin
        wr_en[k] = (beat_count[0] == 1'(k >> 1));
      end
    end
  end

  // odd FIFOs take the high half in 16-bit mode
  always_comb begin
    for (int k = 0; k < NF; k++) begin
      if (!do_8 && (k % 2 == 1)) begin
        wr.pd[k] = dp_pd.bytes[2*HB-1:HB];
      end else begin
        wr.pd[k] = dp_pd.bytes[HB-1:0];
      end
    end
  end

  // unused FIFOs do not hold the beat back
  assign fifo_rdy = wr.prdy | ~wr_en;
  assign dp_ready = &fifo_rdy;

  // a FIFO pair is written together or not at all
  assign wr.pvld    = {NF{dp_valid & dp_ready}} & wr_en;
  assign beat_accept = dp_valid & dp_ready;

  // int8 spreads one word per beat, never two
  always_comb begin
    if (dp_valid === 1'b1 && do_8 === 1'b1) begin
      a_int8_one_fifo : assert final ($onehot(wr_en));
    end
  end

endmodule

`default_nettype wire

// File: sdp_wdma_dfifo.sv
// ==========================================================================
// two-entry data FIFO with valid/ready on both sides
// a write shows at the read side one cycle later; wr_prdy depends only
// on the fill level, never on wr_pvld
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module sdp_wdma_dfifo (
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  logic                        wr_pvld,
  output logic                        wr_prdy,
  input  logic [`SDP_WDMA_FIFO_W-1:0] wr_pd,
  output logic                        rd_pvld,
  input  logic                        rd_prdy,
  output logic [`SDP_WDMA_FIFO_W-1:0] rd_pd
);

  logic [`SDP_WDMA_FIFO_W-1:0] mem [2];
  logic                        wr_ptr;
  logic                        rd_ptr;
  logic [1:0]                  fill;
  logic                        wr_en;
  logic                        rd_en;

  assign wr_prdy = (fill != 2'd2);
  assign rd_pvld = (fill != 2'd0);
  assign rd_pd   = mem[rd_ptr];

  assign wr_en = wr_pvld & wr_prdy;
  assign rd_en = rd_pvld & rd_prdy;

  always_ff @(posedge nvdla_core_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_pd;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      fill   <= 2'd0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ~wr_ptr;
      end
      if (rd_en) begin
        rd_ptr <= ~rd_ptr;
      end
      // simultaneous push and pop keeps the level
      case ({wr_en, rd_en})
        2'b10:   fill <= fill + 2'd1;
        2'b01:   fill <= fill - 2'd1;
        default: fill <= fill;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sdp_wdma_nan_counter.sv
// ==========================================================================
// fp16 NaN lane counter for the status register
// counts only accepted beats while the output precision is fp16
// saturates at all ones; op_load clears it and wins over a count
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module sdp_wdma_nan_counter (
  input  logic                           nvdla_core_clk,
  input  logic                           nvdla_core_rstn,
  input  logic                           op_load,
  input  sdp_wdma_pkg::out_prec_e        out_precision,
  input  sdp_wdma_pkg::wdma_beat_u       dp_pd,
  input  logic                           beat_accept,
  output logic [`SDP_WDMA_NAN_CNT_W-1:0] nan_output_num
);

  localparam int LANES = `SDP_WDMA_FP16_LANES;
  localparam int CNT_W = `SDP_WDMA_NAN_CNT_W;
  localparam int SUM_W = $clog2(LANES + 1);

  logic [LANES-1:0] lane_nan;
  logic [SUM_W-1:0] nan_num;
  logic [CNT_W:0]   cnt_sum;
  logic             cnt_en;

  // all-ones exponent with a nonzero mantissa, infinities excluded
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_nan[i] = (dp_pd.lanes[i].expo == `SDP_WDMA_FP16_EXP_ALL_ONES) &&
                    (dp_pd.lanes[i].mant != '0);
    end
  end

  always_comb begin
    nan_num = '0;
    for (int i = 0; i < LANES; i++) begin
      nan_num = nan_num + SUM_W'(lane_nan[i]);
    end
  end

  assign cnt_en  = beat_accept && (out_precision == sdp_wdma_pkg::out_prec_fp16) && |lane_nan;
  assign cnt_sum = {1'b0, nan_output_num} + (CNT_W + 1)'(nan_num);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nan_output_num <= '0;
    end else if (op_load) begin
      nan_output_num <= '0;
    end else if (cnt_en) begin
      nan_output_num <= cnt_sum[CNT_W] ? '1 : cnt_sum[CNT_W-1:0];
    end
  end

  // only op_load may take the count down, wrap included
  a_cnt_monotonic : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !op_load |=> nan_output_num >= $past(nan_output_num)
  );

endmodule

`default_nettype wire

// File: sdp_wdma_dat_in.sv
// ==========================================================================
// SDP write-DMA data input stage, top level
// command and data arrive on separate valid/ready ports; data of a span
// must follow its command. Words leave on four FIFO read channels
// out_precision and the command stay stable while a span is in flight
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module sdp_wdma_dat_in (
  input  logic                           nvdla_core_clk,
  input  logic                           nvdla_core_rstn,
  input  logic                           cmd_pvld,
  output logic                           cmd_prdy,
  input  logic [`SDP_WDMA_SPAN_W-1:0]    cmd_size,
  input  logic                           dp_valid,
  output logic                           dp_ready,
  input  logic [`SDP_WDMA_BEAT_W-1:0]    dp_pd,
  output logic                           dfifo0_rd_pvld,
  input  logic                           dfifo0_rd_prdy,
  output logic [`SDP_WDMA_FIFO_W-1:0]    dfifo0_rd_pd,
  output logic                           dfifo1_rd_pvld,
  input  logic                           dfifo1_rd_prdy,
  output logic [`SDP_WDMA_FIFO_W-1:0]    dfifo1_rd_pd,
  output logic                           dfifo2_rd_pvld,
  input  logic                           dfifo2_rd_prdy,
  output logic [`SDP_WDMA_FIFO_W-1:0]    dfifo2_rd_pd,
  output logic                           dfifo3_rd_pvld,
  input  logic                           dfifo3_rd_prdy,
  output logic [`SDP_WDMA_FIFO_W-1:0]    dfifo3_rd_pd,
  input  logic [1:0]                     out_precision,
  input  logic                           op_load,
  output logic [`SDP_WDMA_NAN_CNT_W-1:0] nan_output_num
);

  logic [`SDP_WDMA_SPAN_W-1:0] beat_count;
  logic                        beat_accept;
  sdp_wdma_pkg::out_prec_e     out_prec;

  // register field code to enum
  assign out_prec = sdp_wdma_pkg::out_prec_e'(out_precision);

  sdp_wdma_dfifo_if i_dfifo_if ();

  sdp_wdma_span_ctrl i_span_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cmd_pvld        (cmd_pvld),
    .cmd_prdy        (cmd_prdy),
    .cmd_size        (cmd_size),
    .dp_valid        (dp_valid),
    .beat_accept     (beat_accept),
    .beat_count      (beat_count)
  );

  sdp_wdma_beat_router i_beat_router (
    .dp_valid      (dp_valid),
    .dp_pd         (dp_pd),
    .dp_ready      (dp_ready),
    .out_precision (out_prec),
    .beat_count    (beat_count),
    .beat_accept   (beat_accept),
    .wr            (i_dfifo_if.router)
  );

  // ==========================================================================
  // data FIFOs, channel k of the interface feeds FIFO k
  // ==========================================================================
  sdp_wdma_dfifo i_dfifo0 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_pvld         (i_dfifo_if.pvld[0]),
    .wr_prdy         (i_dfifo_if.prdy[0]),
    .wr_pd           (i_dfifo_if.pd[0]),
    .rd_pvld         (dfifo0_rd_pvld),
    .rd_prdy         (dfifo0_rd_prdy),
    .rd_pd           (dfifo0_rd_pd)
  );

  sdp_wdma_dfifo i_dfifo1 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_pvld         (i_dfifo_if.pvld[1]),
    .wr_prdy         (i_dfifo_if.prdy[1]),
    .wr_pd           (i_dfifo_if.pd[1]),
    .rd_pvld         (dfifo1_rd_pvld),
    .rd_prdy         (dfifo1_rd_prdy),
    .rd_pd           (dfifo1_rd_pd)
  );

  sdp_wdma_dfifo i_dfifo2 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_pvld         (i_dfifo_if.pvld[2]),
    .wr_prdy         (i_dfifo_if.prdy[2]),
    .wr_pd           (i_dfifo_if.pd[2]),
    .rd_pvld         (dfifo2_rd_pvld),
    .rd_prdy         (dfifo2_rd_prdy),
    .rd_pd           (dfifo2_rd_pd)
  );

  sdp_wdma_dfifo i_dfifo3 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_pvld         (i_dfifo_if.pvld[3]),
    .wr_prdy         (i_dfifo_if.prdy[3]),
    .wr_pd           (i_dfifo_if.pd[3]),
    .rd_pvld         (dfifo3_rd_pvld),
    .rd_prdy         (dfifo3_rd_prdy),
    .rd_pd           (dfifo3_rd_pd)
  );

  sdp_wdma_nan_counter i_nan_counter (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .out_precision   (out_prec),
    .dp_pd           (dp_pd),
    .beat_accept     (beat_accept),
    .nan_output_num  (nan_output_num)
  );

endmodule

`default_nettype wire

// File: tb_sdp_wdma_checker.sv
// ==========================================================================
// port checker for the SDP write-DMA input stage
// builds one expected word list per FIFO from the beat routing rule and
// compares every word popped at the read ports; samples on the rising edge
// reports one line per test on test_done, errors stay counted to the end
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module wdma_port_checker (
  input  logic                                                 nvdla_core_clk,
  input  logic                                                 nvdla_core_rstn,
  input  logic                                                 cmd_pvld,
  input  logic                                                 cmd_prdy,
  input  logic [`SDP_WDMA_SPAN_W-1:0]                          cmd_size,
  input  logic                                                 dp_valid,
  input  logic                                                 dp_ready,
  input  logic [`SDP_WDMA_BEAT_W-1:0]                          dp_pd,
  input  logic [1:0]                                           out_precision,
  input  logic [`SDP_WDMA_NUM_FIFO-1:0]                        rd_pvld,
  input  logic [`SDP_WDMA_NUM_FIFO-1:0]                        rd_prdy,
  input  logic [`SDP_WDMA_NUM_FIFO-1:0][`SDP_WDMA_FIFO_W-1:0]  rd_pd,
  input  logic [`SDP_WDMA_NAN_CNT_W-1:0]                       nan_output_num,
  input  logic                                                 nan_chk,
  input  logic [`SDP_WDMA_NAN_CNT_W-1:0]                       nan_exp,
  input  logic                                                 test_done,
  input  logic [3:0]                                           test_num,
  output int                                                   error_count,
  output int                                                   tests_run,
  output int                                                   tests_failed,
  output int                                                   words_checked
);

  localparam int NF    = `SDP_WDMA_NUM_FIFO;
  localparam int FW    = `SDP_WDMA_FIFO_W;
  localparam int DEPTH = 256;

  // expected words, one ring per FIFO
  logic [FW-1:0]               exp_mem [NF][DEPTH];
  int                          wr_idx [NF];
  int                          rd_idx [NF];
  logic                        span_act;
  logic [`SDP_WDMA_SPAN_W-1:0] span_len;
  logic [`SDP_WDMA_SPAN_W-1:0] beat_idx;
  int                          err_at_start;

  task automatic expect_word(input int k, input logic [FW-1:0] w);
    exp_mem[k][wr_idx[k] % DEPTH] = w;
    wr_idx[k] = wr_idx[k] + 1;
  endtask

  // int8 puts the low half on FIFO (beat mod 4)
  // 16-bit puts low/high on FIFOs 0/1 for even beats, 2/3 for odd ones
  task automatic expect_beat();
    logic [FW-1:0] lo;
    logic [FW-1:0] hi;
    lo = dp_pd[FW-1:0];
    hi = dp_pd[2*FW-1:FW];
    if (out_precision == sdp_wdma_pkg::out_prec_int8) begin
      expect_word(int'(beat_idx[1:0]), lo);
    end else if (beat_idx[0] == 1'b0) begin
      expect_word(0, lo);
      expect_word(1, hi);
    end else begin
      expect_word(2, lo);
      expect_word(3, hi);
    end
  endtask

  task automatic compare_pop(input int k);
    logic [FW-1:0] exp_w;
    if (rd_idx[k] == wr_idx[k]) begin
      $display("Error at %0t: FIFO %0d delivered a word that was never sent", $time, k);
      error_count = error_count + 1;
    end else begin
      exp_w = exp_mem[k][rd_idx[k] % DEPTH];
      rd_idx[k] = rd_idx[k] + 1;
      words_checked = words_checked + 1;
      if (rd_pd[k] !== exp_w) begin
        $display("Fail at %0t: dfifo%0d_rd_pd expected %h got %h", $time, k, exp_w, rd_pd[k]);
        error_count = error_count + 1;
      end
    end
  endtask

  always @(posedge nvdla_core_clk) begin
    if (!nvdla_core_rstn) begin
      span_act = 1'b0;
      beat_idx = '0;
      span_len = '0;
      for (int k = 0; k < NF; k++) begin
        wr_idx[k] = 0;
        rd_idx[k] = 0;
      end
    end else begin
      for (int k = 0; k < NF; k++) begin
        if (rd_pvld[k] && rd_prdy[k]) begin
          compare_pop(k);
        end
      end
      // beat first, so a command taken on the last beat opens the next span
      if (dp_valid && dp_ready) begin
        if (!span_act) begin
          $display("Error at %0t: beat accepted while no command was open", $time);
          error_count = error_count + 1;
        end else begin
          expect_beat();
          if (beat_idx == span_len) begin
            if (!cmd_prdy) begin
              $display("Error at %0t: cmd_prdy low on the last beat of a span", $time);
              error_count = error_count + 1;
            end
            span_act = 1'b0;
            beat_idx = '0;
          end else begin
            beat_idx = beat_idx + 1'b1;
          end
        end
      end
      if (cmd_pvld && cmd_prdy) begin
        if (span_act) begin
          $display("Error at %0t: command taken while a span was still open", $time);
          error_count = error_count + 1;
        end
        span_act = 1'b1;
        span_len = cmd_size;
      end
      if (nan_chk && nan_output_num !== nan_exp) begin
        $display("Fail at %0t: nan_output_num expected %0d got %0d",
                 $time, nan_exp, nan_output_num);
        error_count = error_count + 1;
      end
      if (test_done) begin
        for (int k = 0; k < NF; k++) begin
          if (rd_idx[k] != wr_idx[k]) begin
            $display("Error at %0t: %0d words for FIFO %0d never reached its read port",
                     $time, wr_idx[k] - rd_idx[k], k);
            error_count = error_count + 1;
            rd_idx[k] = wr_idx[k];
          end
        end
        tests_run = tests_run + 1;
        if (error_count != err_at_start) begin
          tests_failed = tests_failed + 1;
          $display("test %0d failed with %0d errors", test_num, error_count - err_at_start);
        end else begin
          $display("test %0d passed", test_num);
        end
        err_at_start = error_count;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_sdp_wdma_dat_in.sv
// ==========================================================================
// testbench for the SDP write-DMA input stage
// run from the project root, the trace is read as sdp_wdma_trace.txt
// inputs change 10 ns after the rising edge; each wait gives up after
// 2000 cycles. Commands of one test are offered back to back
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module tb_sdp_wdma_dat_in;

  localparam int         TRACE_DEPTH = 128;
  localparam int         REC_W       = `SDP_WDMA_BEAT_W + 8;
  localparam int         LIMIT       = 2000;
  localparam logic [7:0] TAG_SPAN    = 8'h01;
  localparam logic [7:0] TAG_BEAT    = 8'h02;
  localparam logic [7:0] TAG_NAN     = 8'h03;
  localparam logic [7:0] TAG_LOAD    = 8'h04;
  localparam logic [7:0] TAG_END     = 8'h05;

  logic                                                 nvdla_core_clk;
  logic                                                 nvdla_core_rstn;
  logic                                                 cmd_pvld;
  wire                                                  cmd_prdy;
  logic [`SDP_WDMA_SPAN_W-1:0]                          cmd_size;
  logic                                                 dp_valid;
  wire                                                  dp_ready;
  logic [`SDP_WDMA_BEAT_W-1:0]                          dp_pd;
  wire  [`SDP_WDMA_NUM_FIFO-1:0]                        rd_pvld;
  logic [`SDP_WDMA_NUM_FIFO-1:0]                        rd_prdy;
  wire  [`SDP_WDMA_NUM_FIFO-1:0][`SDP_WDMA_FIFO_W-1:0]  rd_pd;
  logic [1:0]                                           out_precision;
  logic                                                 op_load;
  wire  [`SDP_WDMA_NAN_CNT_W-1:0]                       nan_output_num;

  logic                              nan_chk;
  logic [`SDP_WDMA_NAN_CNT_W-1:0]    nan_exp;
  logic                              test_done;
  logic [3:0]                        test_num;
  int                                error_count;
  int                                tests_run;
  int                                tests_failed;
  int                                words_checked;
  int                                tests_expected;
  int                                cmds_taken;
  logic                              bp_random;
  logic [31:0]                       lcg_state;

  // record: payload above an 8-bit tag
  logic [REC_W-1:0]                  trace_mem [TRACE_DEPTH];
  logic [`SDP_WDMA_SPAN_W-1:0]       span_size_q [$];
  logic [1:0]                        span_prec_q [$];
  logic [`SDP_WDMA_BEAT_W-1:0]       beat_q [$];

  sdp_wdma_dat_in i_sdp_wdma_dat_in (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cmd_pvld        (cmd_pvld),
    .cmd_prdy        (cmd_prdy),
    .cmd_size        (cmd_size),
    .dp_valid        (dp_valid),
    .dp_ready        (dp_ready),
    .dp_pd           (dp_pd),
    .dfifo0_rd_pvld  (rd_pvld[0]),
    .dfifo0_rd_prdy  (rd_prdy[0]),
    .dfifo0_rd_pd    (rd_pd[0]),
    .dfifo1_rd_pvld  (rd_pvld[1]),
    .dfifo1_rd_prdy  (rd_prdy[1]),
    .dfifo1_rd_pd    (rd_pd[1]),
    .dfifo2_rd_pvld  (rd_pvld[2]),
    .dfifo2_rd_prdy  (rd_prdy[2]),
    .dfifo2_rd_pd    (rd_pd[2]),
    .dfifo3_rd_pvld  (rd_pvld[3]),
    .dfifo3_rd_prdy  (rd_prdy[3]),
    .dfifo3_rd_pd    (rd_pd[3]),
    .out_precision   (out_precision),
    .op_load         (op_load),
    .nan_output_num  (nan_output_num)
  );

  wdma_port_checker i_port_checker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cmd_pvld        (cmd_pvld),
    .cmd_prdy        (cmd_prdy),
    .cmd_size        (cmd_size),
    .dp_valid        (dp_valid),
    .dp_ready        (dp_ready),
    .dp_pd           (dp_pd),
    .out_precision   (out_precision),
    .rd_pvld         (rd_pvld),
    .rd_prdy         (rd_prdy),
    .rd_pd           (rd_pd),
    .nan_output_num  (nan_output_num),
    .nan_chk         (nan_chk),
    .nan_exp         (nan_exp),
    .test_done       (test_done),
    .test_num        (test_num),
    .error_count     (error_count),
    .tests_run       (tests_run),
    .tests_failed    (tests_failed),
    .words_checked   (words_checked)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic abort_run(input string why);
    $display("Error at %0t: %s", $time, why);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic drive_commands();
    int t;
    for (int s = 0; s < span_size_q.size(); s++) begin
      cmd_pvld = 1'b1;
      cmd_size = span_size_q[s];
      t = 0;
      do begin
        @(posedge nvdla_core_clk);
        t++;
      end while (!cmd_prdy && t < LIMIT);
      if (!cmd_prdy) begin
        abort_run("cmd_prdy stayed low, command not accepted");
      end
      cmds_taken++;
      #10;
    end
    cmd_pvld = 1'b0;
  endtask

  task automatic drive_beats();
    int t;
    for (int s = 0; s < span_size_q.size(); s++) begin
      t = 0;
      while (cmds_taken <= s && t < LIMIT) begin
        @(posedge nvdla_core_clk);
        #10;
        t++;
      end
      if (cmds_taken <= s) begin
        abort_run("no command accepted for the next span");
      end
      // precision moves only between spans
      out_precision = span_prec_q[s];
      for (int b = 0; b <= int'(span_size_q[s]); b++) begin
        dp_valid = 1'b1;
        dp_pd    = beat_q.pop_front();
        t = 0;
        do begin
          @(posedge nvdla_core_clk);
          t++;
        end while (!dp_ready && t < LIMIT);
        if (!dp_ready) begin
          abort_run("dp_ready stayed low, beat not accepted");
        end
        #10;
      end
    end
    dp_valid = 1'b0;
  endtask

  task automatic drain_fifos();
    int t;
    t = 0;
    do begin
      @(posedge nvdla_core_clk);
      t++;
    end while (rd_pvld != '0 && t < LIMIT);
    if (rd_pvld != '0) begin
      abort_run("read ports never drained");
    end
    #10;
  endtask

  task automatic run_pending();
    int nbeats;
    nbeats = 0;
    foreach (span_size_q[s]) begin
      nbeats += int'(span_size_q[s]) + 1;
    end
    if (nbeats != beat_q.size()) begin
      abort_run("trace beat lines do not match the span sizes");
    end
    if (span_size_q.size() != 0) begin
      cmds_taken = 0;
      fork
        drive_commands();
        drive_beats();
      join
      drain_fifos();
      span_size_q.delete();
      span_prec_q.delete();
    end
  endtask

  task automatic check_nan(input logic [`SDP_WDMA_NAN_CNT_W-1:0] expected);
    nan_exp = expected;
    nan_chk = 1'b1;
    @(posedge nvdla_core_clk);
    #10;
    nan_chk = 1'b0;
  endtask

  task automatic pulse_op_load();
    op_load = 1'b1;
    @(posedge nvdla_core_clk);
    #10;
    op_load = 1'b0;
  endtask

  task automatic finish_test(input logic [3:0] num);
    test_num  = num;
    test_done = 1'b1;
    @(posedge nvdla_core_clk);
    #10;
    test_done = 1'b0;
    tests_expected++;
  endtask

  initial begin
    nvdla_core_clk = 1'b0;
    forever begin
      #50 nvdla_core_clk = ~nvdla_core_clk;
    end
  end

  // read back-pressure, random only while a test asks for it
  initial begin
    rd_prdy   = '1;
    lcg_state = 32'd26093;
    forever begin
      @(posedge nvdla_core_clk);
      #10;
      if (bp_random) begin
        lcg_state = lcg_next(lcg_state);
        rd_prdy   = lcg_state[19:16];
      end else begin
        rd_prdy = '1;
      end
    end
  end

  initial begin
    logic [REC_W-1:0] rec;
    int               idx;
    $timeformat(-9, 0, " ns", 0);
    nvdla_core_rstn = 1'b0;
    cmd_pvld        = 1'b0;
    cmd_size        = '0;
    dp_valid        = 1'b0;
    dp_pd           = '0;
    out_precision   = 2'd0;
    op_load         = 1'b0;
    nan_chk         = 1'b0;
    nan_exp         = '0;
    test_done       = 1'b0;
    test_num        = '0;
    bp_random       = 1'b0;
    tests_expected  = 0;
    cmds_taken      = 0;
    for (int i = 0; i < TRACE_DEPTH; i++) begin
      trace_mem[i] = '0;
    end
    $readmemh("sdp_wdma_trace.txt", trace_mem);
    repeat (8) @(posedge nvdla_core_clk);
    #10;
    nvdla_core_rstn = 1'b1;
    idx = 0;
    while (idx < TRACE_DEPTH && trace_mem[idx][7:0] != 8'h00) begin
      rec = trace_mem[idx];
      case (rec[7:0])
        TAG_SPAN: begin
          span_size_q.push_back(rec[8 +: `SDP_WDMA_SPAN_W]);
          span_prec_q.push_back(rec[24 +: 2]);
          bp_random = rec[28];
        end
        TAG_BEAT: beat_q.push_back(rec[REC_W-1:8]);
        TAG_NAN: begin
          run_pending();
          check_nan(rec[8 +: `SDP_WDMA_NAN_CNT_W]);
        end
        TAG_LOAD: begin
          run_pending();
          pulse_op_load();
        end
        TAG_END: begin
          run_pending();
          finish_test(rec[11:8]);
        end
        default: abort_run("unknown record tag in the trace");
      endcase
      idx++;
    end
    if (tests_run == 0 || words_checked == 0) begin
      $display("Error: no data reached the read ports, the trace may be missing");
    end
    $display("tests run %0d of %0d, failed %0d, words checked %0d, errors %0d",
             tests_run, tests_expected, tests_failed, words_checked, error_count);
    if (error_count == 0 && tests_failed == 0 && tests_run == tests_expected &&
        words_checked > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sdp_wdma_trace.txt
// one hex record per line, payload then an 8-bit tag in the low byte
// 01 span: back-pressure, precision, 16-bit size | 02 beat: 256-bit data
// 03 expected NaN count | 04 op_load pulse | 05 end of test, test number
0_0_0003_01
f1000007_f1000006_f1000005_f1000004_01000003_01000002_01000001_01000000_02
f1100007_f1100006_f1100005_f1100004_01100003_01100002_01100001_01100000_02
f1200007_f1200006_f1200005_f1200004_01200003_01200002_01200001_01200000_02
f1300007_f1300006_f1300005_f1300004_01300003_01300002_01300001_01300000_02
1_05
0_1_0002_01
f2000007_f2000006_f2000005_f2000004_02000003_02000002_02000001_02000000_02
f2100007_f2100006_f2100005_f2100004_02100003_02100002_02100001_02100000_02
f2200007_f2200006_f2200005_f2200004_02200003_02200002_02200001_02200000_02
2_05
0_0_0001_01
f3000007_f3000006_f3000005_f3000004_03000003_03000002_03000001_03000000_02
f3100007_f3100006_f3100005_f3100004_03100003_03100002_03100001_03100000_02
0_1_0001_01
f3200007_f3200006_f3200005_f3200004_03200003_03200002_03200001_03200000_02
f3300007_f3300006_f3300005_f3300004_03300003_03300002_03300001_03300000_02
3_05
1_1_0003_01
f4000007_f4000006_f4000005_f4000004_04000003_04000002_04000001_04000000_02
f4100007_f4100006_f4100005_f4100004_04100003_04100002_04100001_04100000_02
f4200007_f4200006_f4200005_f4200004_04200003_04200002_04200001_04200000_02
f4300007_f4300006_f4300005_f4300004_04300003_04300002_04300001_04300000_02
4_05
0_2_0001_01
7e003c00_7c00fc01_00007fff_7bffffff_fc007c01_12340001_7d004000_8000fe00_02
7e003c00_7c00fc01_00007fff_7bffffff_fc007c01_12340001_7d004000_8000fe00_02
0_1_0001_01
7e003c00_7c00fc01_00007fff_7bffffff_fc007c01_12340001_7d004000_8000fe00_02
7e003c00_7c00fc01_00007fff_7bffffff_fc007c01_12340001_7d004000_8000fe00_02
e_03
5_05
0_04
0_03
6_05

// File: src.f
+incdir+.
sdp_wdma_pkg.sv
sdp_wdma_dfifo_if.sv
sdp_wdma_span_ctrl.sv
sdp_wdma_beat_router.sv
sdp_wdma_dfifo.sv
sdp_wdma_nan_counter.sv
sdp_wdma_dat_in.sv
tb_sdp_wdma_checker.sv
tb_sdp_wdma_dat_in.sv
